/* hdl/sb_fifo_cfg_pkg.sv */
package sb_fifo_cfg_pkg;

  // --------------------------------------------------------------------------
  // queue geometry
  // --------------------------------------------------------------------------

  // entries per class queue
  // must stay a power of two so the gray pointer wraps cleanly
  localparam int ASYNC_DEPTH = 4;

  localparam int ADDR_WIDTH = 2;           // storage index, log2 of the depth
  localparam int PTR_WIDTH  = 3;           // storage index plus one wrap bit

  // full detection compares the top two gray bits inverted and the rest
  // equal, so PTR_WIDTH has to be at least 2

  // --------------------------------------------------------------------------
  // flit payload
  // --------------------------------------------------------------------------

  localparam int PLD_WIDTH = 8;            // one sideband data byte per flit

endpackage

/* hdl/sb_flit_pkg.sv */
package sb_flit_pkg;

  import sb_fifo_cfg_pkg::*;

  // --------------------------------------------------------------------------
  // flit carried by both message classes
  // --------------------------------------------------------------------------

  typedef struct packed {
    logic                 eom;             // last flit of the message
    logic                 parity;          // even parity over eom and data
    logic [PLD_WIDTH-1:0] data;
  } sb_flit_t;

  // pointer in gray code, the only form that crosses between the clocks
  typedef logic [PTR_WIDTH-1:0] sb_gray_ptr_t;

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // even parity, so eom, data and the parity bit xor to zero together
  function automatic logic sb_flit_parity(input sb_flit_t flit);
    logic p;
    p = ^{flit.eom, flit.data};
    return p;
  endfunction

endpackage

/* hdl/sb_ing_queue.sv */
`timescale 1ns/10ps

module sb_ing_queue
  import sb_fifo_cfg_pkg::*;
  import sb_flit_pkg::*;
(
  input  logic                  ing_side_clk,
  input  logic                  ing_side_rst_b,

  // source strobes, ingress clock
  input  logic                  irdy,
  input  sb_flit_t              flit,
  output logic                  trdy,

  // from the egress side of the same class
  input  sb_gray_ptr_t          rd_gray,     // egress clock domain
  input  logic [ADDR_WIDTH-1:0] rd_addr,

  // to the egress side of the same class
  output sb_gray_ptr_t          wr_gray,
  output sb_flit_t              rd_flit,

  output logic                  idle
);

  // --------------------------------------------------------------------------
  // declarations
  // --------------------------------------------------------------------------

  sb_flit_t             mem [ASYNC_DEPTH];   // queue entries
  logic [PTR_WIDTH-1:0] wr_bin;
  logic [PTR_WIDTH-1:0] wr_bin_nxt;
  sb_gray_ptr_t         rd_gray_s1;          // first sync stage
  sb_gray_ptr_t         rd_gray_s2;
  logic [PTR_WIDTH-1:0] rd_bin_s;            // synced read pointer in binary
  logic [PTR_WIDTH-1:0] occupancy;
  logic                 full;
  logic                 push;

  // --------------------------------------------------------------------------
  // read pointer synchronizer
  // --------------------------------------------------------------------------

  always_ff @(posedge ing_side_clk or negedge ing_side_rst_b) begin
    if (!ing_side_rst_b) begin
      rd_gray_s1 <= '0;
      rd_gray_s2 <= '0;
    end else begin
      rd_gray_s1 <= rd_gray;
      rd_gray_s2 <= rd_gray_s1;
    end
  end

  // each binary bit is the xor of all gray bits at and above it
  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      rd_bin_s[i] = ^(rd_gray_s2 >> i);
    end
  end

  // --------------------------------------------------------------------------
  // full detect and write strobe
  // --------------------------------------------------------------------------

  // writer is one lap ahead: top two gray bits flipped, lower bits equal
  always_comb begin
    full = (wr_gray[PTR_WIDTH-1:PTR_WIDTH-2] == ~rd_gray_s2[PTR_WIDTH-1:PTR_WIDTH-2]) &&
           (wr_gray[PTR_WIDTH-3:0] == rd_gray_s2[PTR_WIDTH-3:0]);
  end

  assign trdy       = ~full;
  assign push       = irdy & trdy;               // transfer on this edge
  assign wr_bin_nxt = wr_bin + PTR_WIDTH'(push);

  // --------------------------------------------------------------------------
  // write pointer, binary and registered gray copy
  // --------------------------------------------------------------------------

  always_ff @(posedge ing_side_clk or negedge ing_side_rst_b) begin
    if (!ing_side_rst_b) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else begin
      wr_bin  <= wr_bin_nxt;
      wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);   // glitch free for the sync
    end
  end

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------

  always_ff @(posedge ing_side_clk) begin
    if (push) begin
      mem[wr_bin[ADDR_WIDTH-1:0]] <= flit;
    end
  end

  // read port is addressed from the egress side
  // the entry is stable by the time egress sees the new write pointer
  assign rd_flit = mem[rd_addr];

  // nothing written that the reader has not yet been seen to take
  assign idle = (wr_gray == rd_gray_s2);

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  assign occupancy = wr_bin - rd_bin_s;

  // the write pointer never gets more than one full queue ahead of the
  // read pointer as it arrives from egress, so no entry is overwritten
  a_no_write_full: assert property (
    @(posedge ing_side_clk) disable iff (!ing_side_rst_b)
    occupancy <= PTR_WIDTH'(ASYNC_DEPTH)
  ) else $error("ingress queue written while full");

endmodule

/* hdl/sb_egr_queue.sv */
`timescale 1ns/10ps

module sb_egr_queue
  import sb_fifo_cfg_pkg::*;
  import sb_flit_pkg::*;
(
  input  logic                  egr_side_clk,
  input  logic                  egr_side_rst_b,

  // sink strobes, egress clock
  input  logic                  trdy,
  output logic                  irdy,
  output sb_flit_t              flit,

  // from the ingress side of the same class
  input  sb_gray_ptr_t          wr_gray,     // ingress clock domain
  input  sb_flit_t              rd_flit,

  // back to the ingress side
  output sb_gray_ptr_t          rd_gray,
  output logic [ADDR_WIDTH-1:0] rd_addr,

  input  logic                  cfg_parityckdef,   // 1 defeats the check
  output logic                  parity_err,
  output logic                  idle
);

  // --------------------------------------------------------------------------
  // declarations
  // --------------------------------------------------------------------------

  sb_gray_ptr_t         wr_gray_s1;
  sb_gray_ptr_t         wr_gray_s2;          // write pointer, egress view
  logic [PTR_WIDTH-1:0] wr_bin_s;
  logic [PTR_WIDTH-1:0] rd_bin;
  logic [PTR_WIDTH-1:0] rd_bin_nxt;
  logic [PTR_WIDTH-1:0] egr_occ;             // entries as seen by egress
  logic                 empty;
  logic                 pop;
  logic                 par_bad;

  // --------------------------------------------------------------------------
  // write pointer synchronizer
  // --------------------------------------------------------------------------

  always_ff @(posedge egr_side_clk or negedge egr_side_rst_b) begin
    if (!egr_side_rst_b) begin
      wr_gray_s1 <= '0;
      wr_gray_s2 <= '0;
    end else begin
      wr_gray_s1 <= wr_gray;
      wr_gray_s2 <= wr_gray_s1;
    end
  end

  always_comb begin
    for (int i = 0; i < PTR_WIDTH; i++) begin
      wr_bin_s[i] = ^(wr_gray_s2 >> i);      // gray to binary
    end
  end

  // --------------------------------------------------------------------------
  // empty detect and read strobe
  // --------------------------------------------------------------------------

  assign empty = (rd_gray == wr_gray_s2);
  assign irdy  = ~empty;
  assign pop   = irdy & trdy;

  // head of queue straight from storage
  assign flit    = rd_flit;
  assign rd_addr = rd_bin[ADDR_WIDTH-1:0];

  assign rd_bin_nxt = rd_bin + PTR_WIDTH'(pop);

  // --------------------------------------------------------------------------
  // read pointer
  // --------------------------------------------------------------------------

  always_ff @(posedge egr_side_clk or negedge egr_side_rst_b) begin
    if (!egr_side_rst_b) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else begin
      rd_bin  <= rd_bin_nxt;
      rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
    end
  end

  // --------------------------------------------------------------------------
  // parity check
  // --------------------------------------------------------------------------

  assign par_bad = (sb_flit_parity(rd_flit) != rd_flit.parity);

  // sticky until egress reset
  always_ff @(posedge egr_side_clk or negedge egr_side_rst_b) begin
    if (!egr_side_rst_b) begin
      parity_err <= 1'b0;
    end else if (pop && par_bad && !cfg_parityckdef) begin
      parity_err <= 1'b1;
    end
  end

  assign idle = empty;                       // nothing left to hand out

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  assign egr_occ = wr_bin_s - rd_bin;

  // a pop always takes an entry the synced write pointer already covers
  a_no_pop_empty: assert property (
    @(posedge egr_side_clk) disable iff (!egr_side_rst_b)
    pop |-> (egr_occ != '0) && (egr_occ <= PTR_WIDTH'(ASYNC_DEPTH))
  ) else $error("egress queue popped while empty");

  // a stalled head entry is not touched by ingress writes
  a_hold_stalled: assert property (
    @(posedge egr_side_clk) disable iff (!egr_side_rst_b)
    irdy && !trdy |=> irdy && $stable(flit)
  ) else $error("egress flit changed while stalled");

endmodule

/* hdl/sb_async_fifo.sv */
`timescale 1ns/10ps

module sb_async_fifo
  import sb_fifo_cfg_pkg::*;
  import sb_flit_pkg::*;
(
  // ingress side
  input  logic     ing_side_clk,
  input  logic     ing_side_rst_b,
  input  logic     pcirdy,
  input  logic     npirdy,
  input  sb_flit_t pc_flit,
  input  sb_flit_t np_flit,
  output logic     pctrdy,
  output logic     nptrdy,
  output logic     fifo_idle,

  // egress side
  input  logic     egr_side_clk,
  input  logic     egr_side_rst_b,
  input  logic     epctrdy,
  input  logic     enptrdy,
  input  logic     cfg_parityckdef,
  output logic     epcirdy,
  output logic     enpirdy,
  output sb_flit_t opc_flit,
  output sb_flit_t enp_flit,
  output logic     parity_err_out,
  output logic     agent_idle
);

  // --------------------------------------------------------------------------
  // per-class crossing signals
  // --------------------------------------------------------------------------

  sb_gray_ptr_t          pc_wr_gray, np_wr_gray;
  sb_gray_ptr_t          pc_rd_gray, np_rd_gray;
  logic [ADDR_WIDTH-1:0] pc_rd_addr, np_rd_addr;
  sb_flit_t              pc_rd_flit, np_rd_flit;
  logic                  pc_ing_idle, np_ing_idle;
  logic                  pc_egr_idle, np_egr_idle;
  logic                  pc_par_err, np_par_err;

  // both classes must be quiet before either side reports idle
  assign fifo_idle      = pc_ing_idle & np_ing_idle;
  assign agent_idle     = pc_egr_idle & np_egr_idle;
  assign parity_err_out = pc_par_err | np_par_err;

  // posted class
  sb_ing_queue ing_pc (
    .ing_side_clk   (ing_side_clk),   .ing_side_rst_b (ing_side_rst_b),
    .irdy           (pcirdy),         .flit           (pc_flit),
    .trdy           (pctrdy),         .rd_gray        (pc_rd_gray),
    .rd_addr        (pc_rd_addr),     .wr_gray        (pc_wr_gray),
    .rd_flit        (pc_rd_flit),     .idle           (pc_ing_idle)
  );

  sb_egr_queue egr_pc (
    .egr_side_clk   (egr_side_clk),   .egr_side_rst_b (egr_side_rst_b),
    .trdy           (epctrdy),        .irdy           (epcirdy),
    .flit           (opc_flit),       .wr_gray        (pc_wr_gray),
    .rd_flit        (pc_rd_flit),     .rd_gray        (pc_rd_gray),
    .rd_addr        (pc_rd_addr),     .cfg_parityckdef(cfg_parityckdef),
    .parity_err     (pc_par_err),     .idle           (pc_egr_idle)
  );

  // non-posted class, fully independent of posted
  sb_ing_queue ing_np (
    .ing_side_clk   (ing_side_clk),   .ing_side_rst_b (ing_side_rst_b),
    .irdy           (npirdy),         .flit           (np_flit),
    .trdy           (nptrdy),         .rd_gray        (np_rd_gray),
    .rd_addr        (np_rd_addr),     .wr_gray        (np_wr_gray),
    .rd_flit        (np_rd_flit),     .idle           (np_ing_idle)
  );

  sb_egr_queue egr_np (
    .egr_side_clk   (egr_side_clk),   .egr_side_rst_b (egr_side_rst_b),
    .trdy           (enptrdy),        .irdy           (enpirdy),
    .flit           (enp_flit),       .wr_gray        (np_wr_gray),
    .rd_flit        (np_rd_flit),     .rd_gray        (np_rd_gray),
    .rd_addr        (np_rd_addr),     .cfg_parityckdef(cfg_parityckdef),
    .parity_err     (np_par_err),     .idle           (np_egr_idle)
  );

endmodule

/* include/sb_tb_util.svh */
`ifndef SB_TB_UTIL_SVH
`define SB_TB_UTIL_SVH

// ----------------------------------------------------------------------------
// random bits
// ----------------------------------------------------------------------------

// galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
  logic [31:0] nxt;
  nxt = state >> 1;
  if (state[0]) begin
    nxt = nxt ^ 32'h8020_0003;
  end
  return nxt;
endfunction

// gathers n bits, one lfsr step per bit, lsb first out of the state
function automatic logic [31:0] rand_bits(inout logic [31:0] state,
                                          input int unsigned n);
  logic [31:0] bits;
  bits = '0;
  for (int unsigned i = 0; i < n; i++) begin
    bits  = {bits[30:0], state[0]};
    state = lfsr_step(state);
  end
  return bits;
endfunction

// ----------------------------------------------------------------------------
// reporting
// ----------------------------------------------------------------------------

task automatic report_test(input string name, input int unsigned errors);
  $display("[%0t] test %s : %s (%0d errors)", $time, name,
           (errors == 0) ? "ok" : "FAILED", errors);
endtask

`endif

/* bench/tb_sb_async_fifo.sv */
`timescale 1ns/10ps

module tb_sb_async_fifo
  import sb_fifo_cfg_pkg::*;
  import sb_flit_pkg::*;
();

  `include "sb_tb_util.svh"

  // every flit the tests send, both classes, all runs
  localparam int TOTAL_FLITS     = 2 * 300 + 60 + 8 + 2 * 6 + 2 * 20;
  localparam int WATCHDOG_CYCLES = TOTAL_FLITS * 40;

  // --------------------------------------------------------------------------
  // DUT signals and testbench state
  // --------------------------------------------------------------------------

  logic     ing_side_clk = 1'b0;
  logic     egr_side_clk = 1'b0;
  logic     ing_side_rst_b, egr_side_rst_b;
  logic     pcirdy, npirdy, pctrdy, nptrdy, fifo_idle;
  sb_flit_t pc_flit, np_flit, opc_flit, enp_flit;
  logic     epctrdy, enptrdy, cfg_parityckdef;
  logic     epcirdy, enpirdy, parity_err_out, agent_idle;

  sb_flit_t    pc_model[$];                 // flits in flight, per class
  sb_flit_t    np_model[$];
  int          pc_tx, np_tx, pc_rx, np_rx;
  int          test_errs;
  int          n_pass, n_fail;
  logic        np_block;                    // holds enptrdy low
  logic        perr_expect;                 // sticky error expected
  logic [31:0] ing_lfsr, egr_lfsr;

  always #5 ing_side_clk = ~ing_side_clk;
  always #7 egr_side_clk = ~egr_side_clk;

  sb_async_fifo uut (.*);

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  function automatic logic even_parity(input logic eom, input logic [PLD_WIDTH-1:0] data);
    return ^{eom, data};
  endfunction

  function automatic sb_flit_t make_flit(input logic corrupt);
    sb_flit_t    f;
    logic [31:0] r;
    r = rand_bits(ing_lfsr, PLD_WIDTH + 1);
    f.data   = r[PLD_WIDTH-1:0];
    f.eom    = r[PLD_WIDTH];
    f.parity = even_parity(f.eom, f.data) ^ corrupt;   // corrupt inverts it
    return f;
  endfunction

  task automatic log_mismatch(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("Mismatch at %0t: %s got 'h%0h, expected 'h%0h", $time, sig, got, exp);
    test_errs++;
  endtask

  task automatic log_failure(input string what);
    $display("Error at %0t: %s", $time, what);
    test_errs++;
  endtask

  task automatic pulse_reset();
    pcirdy  = 1'b0;
    npirdy  = 1'b0;
    epctrdy = 1'b0;
    enptrdy = 1'b0;
    ing_side_rst_b = 1'b0;
    egr_side_rst_b = 1'b0;
    repeat (3) @(negedge ing_side_clk);
    ing_side_rst_b = 1'b1;
    @(negedge egr_side_clk);
    egr_side_rst_b = 1'b1;
    perr_expect = 1'b0;
    pc_model.delete();
    np_model.delete();
    repeat (2) @(negedge egr_side_clk);
  endtask

  task automatic clear_counts();
    pc_tx = 0;
    np_tx = 0;
    pc_rx = 0;
    np_rx = 0;
  endtask

  // --------------------------------------------------------------------------
  // ingress source, both classes
  // --------------------------------------------------------------------------

  // bad_np is the index of the np flit sent with bad parity, -1 for none
  task automatic ing_traffic(input int n_pc, input int n_np, input int bad_np);
    logic        pend_pc;
    logic        pend_np;
    logic [31:0] r;
    pend_pc = 1'b0;
    pend_np = 1'b0;
    while (pc_tx < n_pc || np_tx < n_np || pend_pc || pend_np) begin
      @(negedge ing_side_clk);
      if (pc_model.size() + np_model.size() != 0) begin
        assert (!fifo_idle) else log_failure("fifo_idle high while flits are in flight");
      end
      if (pend_pc) begin                    // transferred on the last rising edge
        pc_model.push_back(pc_flit);
        pc_tx++;
      end
      if (pend_np) begin
        np_model.push_back(np_flit);
        np_tx++;
      end
      // an offered flit is held until it is taken
      if (!pcirdy || pend_pc) begin
        r      = rand_bits(ing_lfsr, 1);
        pcirdy = (pc_tx < n_pc) && r[0];
        if (pcirdy) pc_flit = make_flit(1'b0);
      end
      if (!npirdy || pend_np) begin
        r      = rand_bits(ing_lfsr, 1);
        npirdy = (np_tx < n_np) && r[0];
        if (npirdy) np_flit = make_flit(np_tx == bad_np);
      end
      pend_pc = pcirdy && pctrdy;           // trdy is steady until the next edge
      pend_np = npirdy && nptrdy;
    end
  endtask

  // --------------------------------------------------------------------------
  // egress sink and scoreboard
  // --------------------------------------------------------------------------

  task automatic pop_and_check(input logic is_np);
    sb_flit_t got;
    sb_flit_t exp;
    logic     have_exp;
    got      = is_np ? enp_flit : opc_flit;
    exp      = '0;
    have_exp = 1'b0;
    if (is_np) begin
      assert (np_model.size() != 0) else log_failure("np flit offered that was never sent");
      if (np_model.size() != 0) begin
        exp      = np_model.pop_front();
        have_exp = 1'b1;
        assert (got == exp) else log_mismatch("enp_flit", 32'(got), 32'(exp));
      end
      np_rx++;
    end else begin
      assert (pc_model.size() != 0) else log_failure("pc flit offered that was never sent");
      if (pc_model.size() != 0) begin
        exp      = pc_model.pop_front();
        have_exp = 1'b1;
        assert (got == exp) else log_mismatch("opc_flit", 32'(got), 32'(exp));
      end
      pc_rx++;
    end
    if (have_exp && exp.parity != even_parity(exp.eom, exp.data) && !cfg_parityckdef) begin
      perr_expect = 1'b1;                   // error is up after this pop edge
    end
  endtask

  task automatic egr_traffic(input int n_pc, input int n_np);
    logic [31:0] r;
    while (pc_rx < n_pc || np_rx < n_np) begin
      @(negedge egr_side_clk);
      assert (parity_err_out == perr_expect) else
        log_mismatch("parity_err_out", 32'(parity_err_out), 32'(perr_expect));
      r       = rand_bits(egr_lfsr, 4);
      epctrdy = (r[1:0] != 2'b00);          // roughly three takes in four
      enptrdy = !np_block && (r[3:2] != 2'b00);
      if (epcirdy && epctrdy) pop_and_check(1'b0);
      if (enpirdy && enptrdy) pop_and_check(1'b1);
    end
    @(negedge egr_side_clk);                // let the last pop edge pass
    epctrdy = 1'b0;
    enptrdy = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!(fifo_idle && agent_idle) && n < 10) begin
      @(negedge egr_side_clk);
      n++;
    end
    assert (fifo_idle && agent_idle) else
      log_failure("idle flags not back within 10 egress cycles");
    assert (pc_model.size() == 0 && np_model.size() == 0) else
      log_failure("flits sent but never received");
  endtask

  task automatic end_test(input string name);
    report_test(name, test_errs);
    if (test_errs == 0) n_pass++;
    else n_fail++;
    test_errs = 0;
  endtask

  // --------------------------------------------------------------------------
  // test sequence
  // --------------------------------------------------------------------------

  initial begin
    pcirdy = 1'b0;
    npirdy = 1'b0;
    pc_flit = '0;
    np_flit = '0;
    epctrdy = 1'b0;
    enptrdy = 1'b0;
    cfg_parityckdef = 1'b0;
    ing_side_rst_b = 1'b0;
    egr_side_rst_b = 1'b0;
    np_block = 1'b0;
    perr_expect = 1'b0;
    test_errs = 0;
    n_pass = 0;
    n_fail = 0;
    ing_lfsr = 32'h5ce2;
    egr_lfsr = 32'h5ce2;
    clear_counts();
    pulse_reset();

    @(negedge ing_side_clk);
    assert (pctrdy) else log_mismatch("pctrdy", 32'(pctrdy), 32'd1);
    assert (nptrdy) else log_mismatch("nptrdy", 32'(nptrdy), 32'd1);
    assert (!epcirdy) else log_mismatch("epcirdy", 32'(epcirdy), 32'd0);
    assert (!enpirdy) else log_mismatch("enpirdy", 32'(enpirdy), 32'd0);
    assert (!parity_err_out) else log_mismatch("parity_err_out", 32'(parity_err_out), 32'd0);
    assert (fifo_idle) else log_mismatch("fifo_idle", 32'(fifo_idle), 32'd1);
    assert (agent_idle) else log_mismatch("agent_idle", 32'(agent_idle), 32'd1);
    end_test("reset values");

    clear_counts();
    fork
      ing_traffic(300, 300, -1);
      egr_traffic(300, 300);
    join
    wait_idle();
    end_test("ordering");

    clear_counts();
    np_block = 1'b1;
    fork
      ing_traffic(60, 8, -1);
      egr_traffic(60, 8);
      begin
        wait (pc_rx == 60);                 // all pc through, np still stuck
        @(negedge ing_side_clk);
        assert (np_tx <= ASYNC_DEPTH) else log_failure("np queue took more than its depth");
        assert (!nptrdy) else log_mismatch("nptrdy", 32'(nptrdy), 32'd0);
        np_block = 1'b0;
      end
    join
    wait_idle();
    end_test("class independence");

    clear_counts();
    fork
      ing_traffic(0, 6, 2);
      egr_traffic(0, 6);
    join
    wait_idle();
    repeat (3) @(negedge egr_side_clk);
    assert (parity_err_out) else log_mismatch("parity_err_out", 32'(parity_err_out), 32'd1);
    pulse_reset();
    cfg_parityckdef = 1'b1;                 // check defeated, error must stay low
    clear_counts();
    fork
      ing_traffic(0, 6, 2);
      egr_traffic(0, 6);
    join
    wait_idle();
    repeat (3) @(negedge egr_side_clk);
    assert (!parity_err_out) else log_mismatch("parity_err_out", 32'(parity_err_out), 32'd0);
    cfg_parityckdef = 1'b0;
    end_test("parity error");

    clear_counts();
    fork
      ing_traffic(20, 20, -1);
      egr_traffic(20, 20);
    join
    wait_idle();
    end_test("idle");

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // watchdog, ends a stuck run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ing_side_clk);
    $display("Error at %0t: run did not finish within %0d ingress cycles",
             $time, WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
hdl/sb_fifo_cfg_pkg.sv
hdl/sb_flit_pkg.sv
hdl/sb_ing_queue.sv
hdl/sb_egr_queue.sv
hdl/sb_async_fifo.sv
bench/tb_sb_async_fifo.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it, and checks the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_sb_async_fifo -f files.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_sb_async_fifo > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  exit 1
fi
exit 0
